/* hdl/pool_pkg.sv */
package pool_pkg;

    // activation stream geometry
    localparam int LANE_W       = 8;
    localparam int IN_LANES     = 24;
    localparam int OUT_LANES    = 12;
    localparam int NARROW_LANES = 6;    // lanes kept when wide mode is off
    localparam int COL_W        = 16;

    // feature-map RAM, one pooled beat per word
    localparam int FMAP_DEPTH = 256;
    localparam int FMAP_AW    = 8;
    localparam int FMAP_DW    = OUT_LANES * LANE_W;

    localparam int AXIL_AW = 16;
    localparam int AXIL_DW = 32;

    // register map
    localparam logic [AXIL_AW-1:0] REG_CTRL   = 16'h0000;
    localparam logic [AXIL_AW-1:0] REG_COL    = 16'h0004;
    localparam logic [AXIL_AW-1:0] REG_STATUS = 16'h0008;
    localparam logic [AXIL_AW-1:0] WIN_BASE   = 16'h1000;   // addr 11:4 word, 3:2 slice

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef logic [IN_LANES-1:0][LANE_W-1:0]  act_beat_t;
    typedef logic [OUT_LANES-1:0][LANE_W-1:0] pool_beat_t;

    typedef struct packed {
        logic       valid;
        logic       row_end;
        pool_beat_t data;
    } pool_out_t;

    typedef struct packed {
        logic             pool_en;
        logic             wide;
        logic [COL_W-1:0] col;
    } pool_cfg_t;

    typedef struct packed {
        logic               req;
        logic               we;
        logic [FMAP_AW-1:0] addr;
        logic [FMAP_DW-1:0] wdata;
    } fmap_req_t;

    typedef struct packed {
        logic               gnt;
        logic               rvalid;   // one cycle after a granted read
        logic [FMAP_DW-1:0] rdata;
    } fmap_rsp_t;

    typedef struct packed {
        logic                 awvalid;
        logic [AXIL_AW-1:0]   awaddr;
        logic                 wvalid;
        logic [AXIL_DW-1:0]   wdata;
        logic [AXIL_DW/8-1:0] wstrb;
        logic                 bready;
        logic                 arvalid;
        logic [AXIL_AW-1:0]   araddr;
        logic                 rready;
    } axil_req_t;

    typedef struct packed {
        logic               awready;
        logic               wready;
        logic               bvalid;
        logic [1:0]         bresp;
        logic               arready;
        logic               rvalid;
        logic [AXIL_DW-1:0] rdata;
        logic [1:0]         rresp;
    } axil_rsp_t;

endpackage

/* hdl/max_pool.sv */
`timescale 1ns/10ps

module max_pool (
    input  logic                clk,
    input  logic                rst_n,
    input  pool_pkg::pool_cfg_t cfg,
    input  logic                in_valid,
    input  pool_pkg::act_beat_t in_data,
    output pool_pkg::pool_out_t pool_out
);
    import pool_pkg::*;

    logic [COL_W-1:0] col_cnt;
    logic             last_beat;

    logic       s1_valid;
    logic       s1_odd;
    logic       s1_last;
    pool_beat_t s1_max;
    pool_beat_t even_buf;      // stage-2 hold for beat 2k
    logic       s2_valid;
    logic       s2_last;
    pool_beat_t s2_max;
    pool_beat_t masked;

    // horizontal max of each lane pair
    function automatic pool_beat_t pair_max(input act_beat_t beat);
        pool_beat_t res;
        for (int i = 0; i < OUT_LANES; i++)
        begin
            res[i] = (beat[2*i] > beat[2*i+1]) ? beat[2*i] : beat[2*i+1];
        end
        return res;
    endfunction

    // vertical max across two beats
    function automatic pool_beat_t beat_max(input pool_beat_t a, input pool_beat_t b);
        pool_beat_t res;
        for (int i = 0; i < OUT_LANES; i++)
        begin
            res[i] = (a[i] > b[i]) ? a[i] : b[i];
        end
        return res;
    endfunction

    // col 0 never reaches the last beat, the count just wraps
    assign last_beat = (col_cnt == cfg.col - 1'b1);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            col_cnt  <= '0;
            s1_valid <= 1'b0;
            s1_odd   <= 1'b0;
            s1_last  <= 1'b0;
            s2_valid <= 1'b0;
            s2_last  <= 1'b0;
        end
        else
        begin
            if (in_valid)
                col_cnt <= last_beat ? '0 : col_cnt + 1'b1;
            s1_valid <= in_valid && cfg.pool_en;
            s1_odd   <= col_cnt[0];
            s1_last  <= last_beat;
            // odd beat closes a pair, a lone even beat closes an odd row
            s2_valid <= s1_valid && (s1_odd || s1_last);
            s2_last  <= s1_valid && s1_last;
        end
    end

    always_ff @(posedge clk)
    begin
        s1_max <= pair_max(in_data);
        if (s1_valid && !s1_odd)
            even_buf <= s1_max;
        s2_max <= s1_odd ? beat_max(even_buf, s1_max) : s1_max;
    end

    always_comb
    begin
        masked = s2_max;
        for (int i = NARROW_LANES; i < OUT_LANES; i++)
        begin
            if (!cfg.wide)
                masked[i] = '0;
        end
    end

    // stage 3, shared with the single bypass register
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            pool_out.valid   <= 1'b0;
            pool_out.row_end <= 1'b0;
        end
        else if (cfg.pool_en)
        begin
            pool_out.valid   <= s2_valid;
            pool_out.row_end <= s2_last;
        end
        else
        begin
            pool_out.valid   <= in_valid;
            pool_out.row_end <= in_valid && last_beat;
        end
    end

    always_ff @(posedge clk)
    begin
        pool_out.data <= cfg.pool_en ? masked : in_data[OUT_LANES-1:0];
    end

endmodule

/* hdl/fmap_writer.sv */
`timescale 1ns/10ps

module fmap_writer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                clear,
    input  pool_pkg::pool_out_t pool_out,
    input  pool_pkg::fmap_rsp_t wr_rsp,
    output pool_pkg::fmap_req_t wr_req,
    output logic [7:0]          wr_count,
    output logic                row_done
);
    import pool_pkg::*;

    logic               req_q;
    logic               row_end_q;
    pool_beat_t         wdata_q;
    logic [FMAP_AW-1:0] wr_addr;   // linear pointer, wraps at FMAP_DEPTH

    assign wr_req = '{req: req_q, we: 1'b1, addr: wr_addr, wdata: wdata_q};

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            req_q     <= 1'b0;
            row_end_q <= 1'b0;
        end
        else if (pool_out.valid)
        begin
            req_q     <= 1'b1;
            row_end_q <= pool_out.row_end;
        end
        else if (wr_rsp.gnt)
        begin
            req_q <= 1'b0;     // held until granted
        end
    end

    always_ff @(posedge clk)
    begin
        if (pool_out.valid)
            wdata_q <= pool_out.data;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n || clear)
        begin
            wr_addr  <= '0;
            wr_count <= '0;
            row_done <= 1'b0;
        end
        else if (wr_rsp.gnt)
        begin
            wr_addr  <= wr_addr + 1'b1;
            wr_count <= wr_count + 1'b1;
            if (row_end_q)
                row_done <= 1'b1;   // sticky until clear
        end
    end

endmodule

/* hdl/fmap_arbiter.sv */
`timescale 1ns/10ps

module fmap_arbiter (
    input  logic                 clk,
    input  logic                 rst_n,
    input  pool_pkg::fmap_req_t  wr_req,
    input  pool_pkg::fmap_req_t  rd_req,
    input  pool_pkg::pool_beat_t ram_rdata,
    output pool_pkg::fmap_rsp_t  wr_rsp,
    output pool_pkg::fmap_rsp_t  rd_rsp,
    output pool_pkg::fmap_req_t  ram_req
);
    import pool_pkg::*;

    logic wr_gnt;
    logic rd_gnt;
    logic wr_rd_pend;   // writer port had a read granted last cycle
    logic rd_rd_pend;

    // stream writer never stalls, so it always wins
    assign wr_gnt = wr_req.req;
    assign rd_gnt = rd_req.req && !wr_req.req;

    always_comb
    begin
        ram_req     = rd_req;
        ram_req.req = wr_gnt || rd_gnt;
        if (wr_gnt)
            ram_req = wr_req;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_rd_pend <= 1'b0;
            rd_rd_pend <= 1'b0;
        end
        else
        begin
            wr_rd_pend <= wr_gnt && !wr_req.we;
            rd_rd_pend <= rd_gnt && !rd_req.we;
        end
    end

    assign wr_rsp = '{gnt: wr_gnt, rvalid: wr_rd_pend, rdata: ram_rdata};
    assign rd_rsp = '{gnt: rd_gnt, rvalid: rd_rd_pend, rdata: ram_rdata};

endmodule

/* hdl/fmap_ram.sv */
`timescale 1ns/10ps

module fmap_ram (
    input  logic                 clk,
    input  pool_pkg::fmap_req_t  ram_req,
    output pool_pkg::pool_beat_t ram_rdata
);
    import pool_pkg::*;

    pool_beat_t mem [FMAP_DEPTH];

    // single port, read data valid the cycle after the request
    always_ff @(posedge clk)
    begin
        if (ram_req.req)
        begin
            if (ram_req.we)
                mem[ram_req.addr] <= ram_req.wdata;
            else
                ram_rdata <= mem[ram_req.addr];
        end
    end

endmodule

/* hdl/pool_csr.sv */
`timescale 1ns/10ps

module pool_csr (
    input  logic                clk,
    input  logic                rst_n,
    input  pool_pkg::axil_req_t axil_req,
    input  logic [7:0]          wr_count,
    input  logic                row_done,
    input  pool_pkg::fmap_rsp_t rd_rsp,
    output pool_pkg::axil_rsp_t axil_rsp,
    output pool_pkg::pool_cfg_t cfg,
    output logic                clear,
    output pool_pkg::fmap_req_t rd_req
);
    import pool_pkg::*;

    logic               idle;
    logic               wr_take;
    logic               ar_take;
    logic               win_hit;
    logic               ctrl_hit;
    logic               col_hit;
    logic               bvalid_q;
    logic               rvalid_q;
    logic               win_req_q;
    logic               win_busy;     // window read waiting for RAM data
    logic [1:0]         bresp_q;
    logic [1:0]         win_slice;
    logic [FMAP_AW-1:0] win_addr;
    logic [AXIL_DW-1:0] rdata_q;
    logic [AXIL_DW-1:0] reg_rdata;
    logic [AXIL_DW-1:0] slice_data;

    // one transaction at a time, writes first
    assign idle     = !bvalid_q && !rvalid_q && !win_busy;
    assign wr_take  = idle && axil_req.awvalid && axil_req.wvalid;
    assign ar_take  = idle && !wr_take && axil_req.arvalid;
    assign win_hit  = (axil_req.araddr[AXIL_AW-1:12] == WIN_BASE[AXIL_AW-1:12]);
    assign ctrl_hit = (axil_req.awaddr == REG_CTRL);
    assign col_hit  = (axil_req.awaddr == REG_COL);

    assign axil_rsp = '{awready: wr_take, wready: wr_take, bvalid: bvalid_q, bresp: bresp_q,
                        arready: ar_take, rvalid: rvalid_q, rdata: rdata_q, rresp: RESP_OKAY};
    assign rd_req   = '{req: win_req_q, we: 1'b0, addr: win_addr, wdata: '0};

    always_comb
    begin
        case (axil_req.araddr)
            REG_CTRL:   reg_rdata = {30'h0, cfg.wide, cfg.pool_en};   // clear reads 0
            REG_COL:    reg_rdata = {16'h0, cfg.col};
            REG_STATUS: reg_rdata = {8'h0, wr_count, 15'h0, row_done};
            default:    reg_rdata = '0;
        endcase
    end

    always_comb
    begin
        case (win_slice)
            2'd0:    slice_data = rd_rsp.rdata[31:0];
            2'd1:    slice_data = rd_rsp.rdata[63:32];
            2'd2:    slice_data = rd_rsp.rdata[95:64];
            default: slice_data = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            bvalid_q <= 1'b0;
            cfg      <= '0;
            clear    <= 1'b0;
        end
        else
        begin
            clear <= 1'b0;
            if (wr_take)
            begin
                bvalid_q <= 1'b1;
                if (ctrl_hit && axil_req.wstrb[0])
                begin
                    cfg.pool_en <= axil_req.wdata[0];
                    cfg.wide    <= axil_req.wdata[1];
                    clear       <= axil_req.wdata[2];   // one-cycle pulse
                end
                if (col_hit && axil_req.wstrb[0])
                    cfg.col[7:0] <= axil_req.wdata[7:0];
                if (col_hit && axil_req.wstrb[1])
                    cfg.col[15:8] <= axil_req.wdata[15:8];
            end
            else if (bvalid_q && axil_req.bready)
            begin
                bvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_take)
            bresp_q <= (ctrl_hit || col_hit) ? RESP_OKAY : RESP_SLVERR;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rvalid_q  <= 1'b0;
            win_req_q <= 1'b0;
            win_busy  <= 1'b0;
        end
        else
        begin
            if (ar_take && win_hit)
            begin
                win_req_q <= 1'b1;
                win_busy  <= 1'b1;
            end
            else if (rd_rsp.gnt)
            begin
                win_req_q <= 1'b0;
            end
            if (rd_rsp.rvalid)
                win_busy <= 1'b0;
            if ((ar_take && !win_hit) || rd_rsp.rvalid)
                rvalid_q <= 1'b1;
            else if (rvalid_q && axil_req.rready)
                rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (ar_take)
        begin
            win_addr  <= axil_req.araddr[11:4];
            win_slice <= axil_req.araddr[3:2];
            if (!win_hit)
                rdata_q <= reg_rdata;
        end
        if (rd_rsp.rvalid)
            rdata_q <= slice_data;
    end

endmodule

/* hdl/pool_layer_top.sv */
`timescale 1ns/10ps

module pool_layer_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  pool_pkg::act_beat_t in_data,
    input  pool_pkg::axil_req_t axil_req,
    output pool_pkg::axil_rsp_t axil_rsp
);
    import pool_pkg::*;

    pool_cfg_t  cfg;
    logic       clear;
    pool_out_t  pool_out;
    fmap_req_t  wr_req;
    fmap_rsp_t  wr_rsp;
    fmap_req_t  rd_req;
    fmap_rsp_t  rd_rsp;
    fmap_req_t  ram_req;
    pool_beat_t ram_rdata;
    logic [7:0] wr_count;
    logic       row_done;

    max_pool u_max_pool (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg      (cfg),
        .in_valid (in_valid),
        .in_data  (in_data),
        .pool_out (pool_out)
    );

    fmap_writer u_fmap_writer (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (clear),
        .pool_out (pool_out),
        .wr_rsp   (wr_rsp),
        .wr_req   (wr_req),
        .wr_count (wr_count),
        .row_done (row_done)
    );

    // writer and host reads share the single RAM port
    fmap_arbiter u_fmap_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_req    (wr_req),
        .rd_req    (rd_req),
        .ram_rdata (ram_rdata),
        .wr_rsp    (wr_rsp),
        .rd_rsp    (rd_rsp),
        .ram_req   (ram_req)
    );

    fmap_ram u_fmap_ram (
        .clk       (clk),
        .ram_req   (ram_req),
        .ram_rdata (ram_rdata)
    );

    pool_csr u_pool_csr (
        .clk      (clk),
        .rst_n    (rst_n),
        .axil_req (axil_req),
        .wr_count (wr_count),
        .row_done (row_done),
        .rd_rsp   (rd_rsp),
        .axil_rsp (axil_rsp),
        .cfg      (cfg),
        .clear    (clear),
        .rd_req   (rd_req)
    );

endmodule

/* sim/pool_layer_assertions.sv */
`timescale 1ns/10ps

module pool_layer_assertions (
    input logic clk,
    input logic rst_n,
    input logic out_valid,
    input logic wr_gnt,
    input logic rd_gnt,
    input logic rd_read,     // granted read on the reader port
    input logic rd_rvalid
);

    // single RAM port
    assert property (@(posedge clk) disable iff (!rst_n) !(wr_gnt && rd_gnt))
        else $error("writer and reader granted in the same cycle");

    assert property (@(posedge clk) disable iff (!rst_n) rd_rvalid == $past(rd_read))
        else $error("read data valid not exactly one cycle after the read grant");

    // pipeline empty right after reset
    assert property (@(posedge clk) $rose(rst_n) |-> !out_valid ##1 !out_valid ##1 !out_valid)
        else $error("pooled output valid within 3 cycles of reset release");

endmodule

bind max_pool pool_layer_assertions u_max_pool_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .out_valid (pool_out.valid),
    .wr_gnt    (1'b0),
    .rd_gnt    (1'b0),
    .rd_read   (1'b0),
    .rd_rvalid (1'b0)
);

bind fmap_arbiter pool_layer_assertions u_arbiter_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .out_valid (1'b0),
    .wr_gnt    (wr_gnt),
    .rd_gnt    (rd_gnt),
    .rd_read   (rd_rsp.gnt && ram_req.req && !ram_req.we),
    .rd_rvalid (rd_rsp.rvalid)
);

/* sim/tb_pool_layer.sv */
`timescale 1ns/10ps

module tb_pool_layer;
    import pool_pkg::*;

    localparam int TIMEOUT = 200;   // cycles per wait loop

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    act_beat_t in_data;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;

    logic [31:0] lfsr;
    act_beat_t   row_beats[$];        // beats of the row being streamed
    pool_beat_t  exp_mem[FMAP_DEPTH]; // expected RAM contents in write order
    int          exp_ptr;
    int          mismatches;
    int          timeouts;

    pool_layer_top DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_data  (in_data),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // max over a 2x2 window, lanes above 6 dropped in narrow mode
    function automatic pool_beat_t pooled_word(input act_beat_t a, input act_beat_t b,
                                               input logic wide);
        pool_beat_t        w;
        logic [LANE_W-1:0] m;
        for (int j = 0; j < OUT_LANES; j++)
        begin
            m = a[2*j];
            if (a[2*j+1] > m)
                m = a[2*j+1];
            if (b[2*j] > m)
                m = b[2*j];
            if (b[2*j+1] > m)
                m = b[2*j+1];
            w[j] = (wide || j < NARROW_LANES) ? m : '0;
        end
        return w;
    endfunction

    task automatic check_val(input logic [31:0] act, input logic [31:0] exp, input string msg);
        if (act !== exp)
        begin
            $display("Fail at %0t ns: %s, got %h expected %h", $time, msg, act, exp);
            mismatches++;
        end
    endtask

    task automatic timeout_error(input string what);
        $display("timeout at %0t ns while waiting for %s", $time, what);
        timeouts++;
    endtask

    task automatic axi_write(input logic [AXIL_AW-1:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int t;
        @(posedge clk);
        axil_req.awvalid <= 1'b1;
        axil_req.awaddr  <= addr;
        axil_req.wvalid  <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= 4'hf;
        t = 0;
        @(negedge clk);
        while (!(axil_rsp.awready && axil_rsp.wready) && t < TIMEOUT)
        begin
            @(negedge clk);
            t++;
        end
        if (!(axil_rsp.awready && axil_rsp.wready))
            timeout_error("awready/wready");
        @(posedge clk);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        t = 0;
        @(negedge clk);
        while (!axil_rsp.bvalid && t < TIMEOUT)
        begin
            @(negedge clk);
            t++;
        end
        if (!axil_rsp.bvalid)
            timeout_error("bvalid");
        resp = axil_rsp.bresp;
        @(posedge clk);   // bready held high
    endtask

    task automatic axi_read(input logic [AXIL_AW-1:0] addr, output logic [31:0] data);
        int t;
        @(posedge clk);
        axil_req.arvalid <= 1'b1;
        axil_req.araddr  <= addr;
        t = 0;
        @(negedge clk);
        while (!axil_rsp.arready && t < TIMEOUT)
        begin
            @(negedge clk);
            t++;
        end
        if (!axil_rsp.arready)
            timeout_error("arready");
        @(posedge clk);
        axil_req.arvalid <= 1'b0;
        t = 0;
        @(negedge clk);
        while (!axil_rsp.rvalid && t < TIMEOUT)
        begin
            @(negedge clk);
            t++;
        end
        if (!axil_rsp.rvalid)
            timeout_error("rvalid");
        data = axil_rsp.rdata;
        check_val(32'(axil_rsp.rresp), 32'(RESP_OKAY), "read response");
        @(posedge clk);   // rready held high
    endtask

    task automatic configure(input logic pool_en, input logic wide, input logic clr,
                             input int n);
        logic [1:0] resp;
        axi_write(REG_COL, 32'(n), resp);
        check_val(32'(resp), 32'(RESP_OKAY), "COL write response");
        axi_write(REG_CTRL, {29'h0, clr, wide, pool_en}, resp);
        check_val(32'(resp), 32'(RESP_OKAY), "CTRL write response");
        if (clr)
            exp_ptr = 0;
    endtask

    task automatic stream_row(input int n);
        act_beat_t   beat;
        logic [31:0] r;
        int          gap;
        for (int b = 0; b < n; b++)
        begin
            gap = rand_bits(2);
            repeat (gap)
            begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
            for (int l = 0; l < IN_LANES; l++)
            begin
                r = rand_bits(LANE_W);
                beat[l] = r[LANE_W-1:0];
            end
            @(posedge clk);
            in_valid <= 1'b1;
            in_data  <= beat;
            row_beats.push_back(beat);
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // a lone last beat is pooled with itself
    task automatic model_row(input logic pool_en, input logic wide, input int n);
        act_beat_t partner;
        int        step;
        step = pool_en ? 2 : 1;
        for (int b = 0; b < n; b += step)
        begin
            partner = (b + 1 < n) ? row_beats[b+1] : row_beats[b];
            if (pool_en)
                exp_mem[exp_ptr] = pooled_word(row_beats[b], partner, wide);
            else
                exp_mem[exp_ptr] = row_beats[b][OUT_LANES-1:0];
            exp_ptr++;
        end
        row_beats.delete();
    endtask

    task automatic wait_for_count(input int n);
        logic [31:0] st;
        int          t;
        t = 0;
        axi_read(REG_STATUS, st);
        while (st[23:16] != 8'(n) && t < TIMEOUT)
        begin
            axi_read(REG_STATUS, st);
            t++;
        end
        if (st[23:16] != 8'(n))
            timeout_error("write count to reach the pooled beats sent");
    endtask

    task automatic check_status(input int n, input logic done);
        logic [31:0] st;
        axi_read(REG_STATUS, st);
        check_val(st, {8'h0, 8'(n), 15'h0, done}, "STATUS");
    endtask

    task automatic verify_word(input int w);
        logic [127:0] flat;
        logic [31:0]  rd;
        flat = {32'h0, exp_mem[w]};   // slice 3 reads zero
        for (int s = 0; s < 4; s++)
        begin
            axi_read(WIN_BASE + 16'(w * 16 + s * 4), rd);
            check_val(rd, flat[s*32 +: 32], $sformatf("word %0d slice %0d", w, s));
        end
    endtask

    initial
    begin
        logic [31:0] rd;
        logic [1:0]  resp;
        lfsr       = 32'h3987;
        exp_ptr    = 0;
        mismatches = 0;
        timeouts   = 0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_data    = '0;
        axil_req   = '0;
        axil_req.bready = 1'b1;
        axil_req.rready = 1'b1;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // register readback, clear bit reads back as zero
        axi_read(REG_CTRL, rd);
        check_val(rd, 32'h0, "CTRL after reset");
        axi_write(REG_CTRL, 32'h7, resp);
        axi_read(REG_CTRL, rd);
        check_val(rd, 32'h3, "CTRL readback");
        axi_write(REG_COL, 32'h1234, resp);
        axi_read(REG_COL, rd);
        check_val(rd, 32'h1234, "COL readback");
        axi_write(16'h0010, 32'h1, resp);
        check_val(32'(resp), 32'(RESP_SLVERR), "bresp for unmapped offset");
        axi_write(REG_STATUS, 32'h1, resp);
        check_val(32'(resp), 32'(RESP_SLVERR), "bresp for STATUS write");

        // even row, wide
        configure(1'b1, 1'b1, 1'b1, 20);
        stream_row(20);
        model_row(1'b1, 1'b1, 20);
        wait_for_count(exp_ptr);
        check_status(exp_ptr, 1'b1);
        for (int w = 0; w < exp_ptr; w++)
            verify_word(w);

        // odd row, narrow
        configure(1'b1, 1'b0, 1'b1, 13);
        stream_row(13);
        model_row(1'b1, 1'b0, 13);
        wait_for_count(exp_ptr);
        check_status(exp_ptr, 1'b1);
        for (int w = 0; w < exp_ptr; w++)
        begin
            verify_word(w);
            axi_read(WIN_BASE + 16'(w * 16 + 4), rd);
            check_val({rd[31:16], 16'h0}, 32'h0, $sformatf("lanes 6-7 of word %0d", w));
            axi_read(WIN_BASE + 16'(w * 16 + 8), rd);
            check_val(rd, 32'h0, $sformatf("lanes 8-11 of word %0d", w));
        end

        // bypass
        configure(1'b0, 1'b0, 1'b1, 9);
        stream_row(9);
        model_row(1'b0, 1'b0, 9);
        wait_for_count(exp_ptr);
        check_status(9, 1'b1);
        for (int w = 0; w < exp_ptr; w++)
            verify_word(w);

        // clear and restart from word 0
        configure(1'b1, 1'b1, 1'b1, 12);
        check_status(0, 1'b0);
        stream_row(12);
        model_row(1'b1, 1'b1, 12);
        wait_for_count(exp_ptr);
        check_status(6, 1'b1);
        for (int w = 0; w < exp_ptr; w++)
            verify_word(w);

        // window reads of the previous row while the next one streams
        fork
            stream_row(12);
            for (int w = 0; w < 6; w++)
                verify_word(w);
        join
        model_row(1'b1, 1'b1, 12);
        wait_for_count(exp_ptr);
        check_status(12, 1'b1);
        for (int w = 0; w < exp_ptr; w++)
            verify_word(w);

        $display("errors: %0d value mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* verilog.f */
hdl/pool_pkg.sv
hdl/max_pool.sv
hdl/fmap_writer.sv
hdl/fmap_arbiter.sv
hdl/fmap_ram.sv
hdl/pool_csr.sv
hdl/pool_layer_top.sv
sim/pool_layer_assertions.sv
sim/tb_pool_layer.sv

/* Bender.yml */
package:
  name: pool_layer

sources:
  - files:
      - hdl/pool_pkg.sv
      - hdl/max_pool.sv
      - hdl/fmap_writer.sv
      - hdl/fmap_arbiter.sv
      - hdl/fmap_ram.sv
      - hdl/pool_csr.sv
      - hdl/pool_layer_top.sv
  - target: simulation
    files:
      - sim/pool_layer_assertions.sv
      - sim/tb_pool_layer.sv
